// ==== src/snes_pkg.sv ====
package snes_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////////////////////////

  // console a-bus address
  typedef logic [23:0] snes_addr_t;
  // console b-bus address
  typedef logic [7:0] snes_pa_t;
  // psram word address, 16-bit words
  typedef logic [22:0] psram_addr_t;

  //////////////////////////////////////////////////////////////////////
  // timing and register constants
  //////////////////////////////////////////////////////////////////////

  // strobe history length
  localparam int SYNC_DEPTH = 8;
  // address and pa pipeline stages
  localparam int ADDR_DELAY = 7;
  // write data pipeline stages
  localparam int DATA_DELAY = 4;
  // memory delay reload for one mcu access
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;
  // roughly 1 ms of cpu clock low at 96 MHz
  localparam int unsigned SNES_DEAD_TIMEOUT = 96000;
  localparam int DEAD_CNT_W = $clog2(SNES_DEAD_TIMEOUT + 1);

  // patched ppu registers
  localparam snes_pa_t PA_213F = 8'h3F;
  localparam snes_pa_t PA_2100 = 8'h00;
  // region flag in $213f
  localparam int REGION_BIT = 4;
  // limit value that means no limit at all
  localparam logic [3:0] BRIGHT_FULL = 4'hF;

  // mcu access fsm, one-hot
  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_RD_ADDR = 5'b00010,
    ST_RD_END  = 5'b00100,
    ST_WR_ADDR = 5'b01000,
    ST_WR_END  = 5'b10000
  } mcu_state_e;

  //////////////////////////////////////////////////////////////////////
  // shared bundles
  //////////////////////////////////////////////////////////////////////

  // synchronized console bus, strobes active low
  typedef struct packed {
    snes_addr_t addr;
    snes_pa_t   pa;
    logic [7:0] data;
    logic [7:0] data_dly;
    logic       read_n;
    logic       write_n;
    logic       romsel_n;
    logic       pard_n;
    logic       pawr_n;
    logic       cpu_clk;
  } snes_bus_t;

  // one-cycle bus events
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic pard_start;
    logic pawr_start;
    logic cycle_start;
    logic cycle_end;
    logic reset_strobe;
  } snes_evt_t;

  // static config from the mcu
  typedef struct packed {
    logic       region;
    logic [3:0] bright_limit;
    snes_addr_t rom_mask;
  } cart_cfg_t;

  // mcu side of the psram
  typedef struct packed {
    logic       access_rd;
    logic       access_wr;
    snes_addr_t addr;
    logic [7:0] wdata;
  } mcu_port_t;

  // ppu register patch result
  typedef struct packed {
    logic       en_213f;
    logic       force_rd;
    logic [7:0] data_213f;
    logic       en_2100;
    logic       force_wr;
    logic [7:0] data_2100;
  } ppu_drive_t;

endpackage

// ==== src/snes_bus_sync.sv ====
module snes_bus_sync
  import snes_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  snes_addr_t snes_addr_in,
  input  snes_pa_t   snes_pa_in,
  input  logic [7:0] snes_data_in,
  input  logic       snes_read_in,
  input  logic       snes_write_in,
  input  logic       snes_romsel_in,
  input  logic       snes_pard_in,
  input  logic       snes_pawr_in,
  input  logic       snes_cpu_clk_in,
  output snes_bus_t  bus,
  output snes_evt_t  evt,
  output logic       dead
);

  // strobe histories, bit 0 newest
  logic [SYNC_DEPTH-1:0] read_hist;
  logic [SYNC_DEPTH-1:0] write_hist;
  logic [SYNC_DEPTH-1:0] romsel_hist;
  logic [SYNC_DEPTH-1:0] pard_hist;
  logic [SYNC_DEPTH-1:0] pawr_hist;
  logic [SYNC_DEPTH-1:0] cpu_hist;

  snes_addr_t addr_pipe [ADDR_DELAY];
  snes_pa_t   pa_pipe [ADDR_DELAY];
  logic [7:0] data_pipe [DATA_DELAY];
  logic [7:0] data_r;

  logic read_lvl;
  logic write_lvl;
  logic romsel_lvl;
  logic pard_lvl;
  logic pawr_lvl;
  logic cpu_lvl;

  logic [DEAD_CNT_W-1:0] dead_cnt;
  logic reset_strobe;

  // neighbouring sample pairs, OR for low runs, AND for high runs
  function automatic logic [5:0] pair_or(input logic [SYNC_DEPTH-1:0] h);
    return h[6:1] | h[7:2];
  endfunction

  function automatic logic [5:0] pair_and(input logic [SYNC_DEPTH-1:0] h);
    return h[6:1] & h[7:2];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // oversampling
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_hist   <= '1;
      write_hist  <= '1;
      romsel_hist <= '1;
      pard_hist   <= '1;
      pawr_hist   <= '1;
      cpu_hist    <= '0;
    end else begin
      read_hist   <= {read_hist[SYNC_DEPTH-2:0], snes_read_in};
      write_hist  <= {write_hist[SYNC_DEPTH-2:0], snes_write_in};
      romsel_hist <= {romsel_hist[SYNC_DEPTH-2:0], snes_romsel_in};
      pard_hist   <= {pard_hist[SYNC_DEPTH-2:0], snes_pard_in};
      pawr_hist   <= {pawr_hist[SYNC_DEPTH-2:0], snes_pawr_in};
      cpu_hist    <= {cpu_hist[SYNC_DEPTH-2:0], snes_cpu_clk_in};
    end
  end

  // strobe asserts after two low samples, cpu clock after two high ones
  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_lvl   <= 1'b1;
      write_lvl  <= 1'b1;
      romsel_lvl <= 1'b1;
      pard_lvl   <= 1'b1;
      pawr_lvl   <= 1'b1;
      cpu_lvl    <= 1'b0;
    end else begin
      read_lvl   <= read_hist[1] | read_hist[0];
      write_lvl  <= write_hist[1] | write_hist[0];
      romsel_lvl <= romsel_hist[1] | romsel_hist[0];
      pard_lvl   <= pard_hist[1] | pard_hist[0];
      pawr_lvl   <= pawr_hist[1] | pawr_hist[0];
      cpu_lvl    <= cpu_hist[1] & cpu_hist[0];
    end
  end

  // address, pa and data pipelines
  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr_in;
    pa_pipe[0]   <= snes_pa_in;
    data_pipe[0] <= snes_data_in;
    data_r       <= snes_data_in;
    for (int i = 1; i < ADDR_DELAY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
      pa_pipe[i]   <= pa_pipe[i-1];
    end
    for (int i = 1; i < DATA_DELAY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // dead / alive tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead         <= 1'b1;
      dead_cnt     <= '0;
      reset_strobe <= 1'b0;
    end else begin
      reset_strobe <= 1'b0;
      if (cpu_lvl) begin
        dead_cnt     <= '0;
        dead         <= 1'b0;
        // console just woke up
        reset_strobe <= dead;
      end else if (dead_cnt != DEAD_CNT_W'(SNES_DEAD_TIMEOUT)) begin
        dead_cnt <= dead_cnt + 1'b1;
      end else begin
        dead <= 1'b1;
      end
    end
  end

  always_comb begin
    bus.addr     = addr_pipe[ADDR_DELAY-1];
    bus.pa       = pa_pipe[ADDR_DELAY-1];
    bus.data     = data_r;
    bus.data_dly = data_pipe[DATA_DELAY-1];
    bus.read_n   = read_lvl;
    bus.write_n  = write_lvl;
    bus.romsel_n = romsel_lvl;
    bus.pard_n   = pard_lvl;
    bus.pawr_n   = pawr_lvl;
    bus.cpu_clk  = cpu_lvl;
  end

  // edges need a stable run of samples before they count
  always_comb begin
    evt.rd_start     = pair_or(read_hist) == 6'b111100;
    evt.rd_end       = pair_and(read_hist) == 6'b000001;
    evt.wr_end       = pair_and(write_hist) == 6'b000001;
    evt.pard_start   = pair_or(pard_hist) == 6'b111110;
    // long low run so write data has settled
    evt.pawr_start   = pair_or(pawr_hist) == 6'b111000;
    evt.cycle_start  = pair_and(cpu_hist) == 6'b000011;
    evt.cycle_end    = pair_or(cpu_hist) == 6'b111000;
    evt.reset_strobe = reset_strobe;
  end

endmodule

// ==== src/mcu_psram_arbiter.sv ====
module mcu_psram_arbiter
  import snes_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  snes_bus_t  bus,
  input  snes_evt_t  evt,
  input  logic       dead,
  input  logic       rom_hit,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  logic [7:0] mcu_wdata,
  input  logic [7:0] rom_byte,
  output mcu_port_t  mcu,
  output logic       mcu_rdy,
  output logic [7:0] mcu_rdata
);

  mcu_state_e state;
  logic [3:0] mem_delay;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  logic       acc_end;
  logic       wake;
  logic       take;
  snes_addr_t addr_r;
  logic [7:0] wdata_r;

  // console coming alive, dead flag not yet cleared
  assign wake    = dead & bus.cpu_clk;
  assign acc_end = (state == ST_RD_END) | (state == ST_WR_END);
  // requests only accepted while ready
  assign take    = mcu_rdy & (mcu_rrq | mcu_wrq);

  // non-rom console cycle leaves the psram free
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = evt.cycle_end | free_strobe;

  //////////////////////////////////////////////////////////////////////
  // request latching
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rdy & mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_rdy & mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (acc_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (take) begin
      addr_r  <= mcu_addr;
      wdata_r <= mcu_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // access fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset | wake) begin
      // pending request survives a wake and restarts later
      state     <= ST_IDLE;
      mem_delay <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot | dead) begin
            if (rd_pend) begin
              state     <= ST_RD_ADDR;
              mem_delay <= ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state     <= ST_WR_ADDR;
              mem_delay <= ROM_CYCLE_LEN;
            end
          end
        end
        ST_RD_ADDR: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) begin
            state <= ST_RD_END;
          end
        end
        ST_WR_ADDR: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) begin
            state <= ST_WR_END;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // last sample before the end state is the one kept
  always_ff @(posedge CLK2) begin
    if (state == ST_RD_ADDR) begin
      mcu_rdata <= rom_byte;
    end
  end

  always_comb begin
    mcu.access_rd = state == ST_RD_ADDR;
    mcu.access_wr = state == ST_WR_ADDR;
    mcu.addr      = addr_r;
    mcu.wdata     = wdata_r;
  end

endmodule

// ==== src/ppu_reg_patch.sv ====
module ppu_reg_patch
  import snes_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  snes_bus_t  bus,
  input  snes_evt_t  evt,
  input  cart_cfg_t  cfg,
  output ppu_drive_t drive
);

  logic       hit_213f;
  logic       hit_2100;
  logic       limit_on;
  logic       over_limit;
  logic       cap_213f;
  logic       cap_2100;
  logic [7:0] region_byte;
  logic       force_rd;
  logic       force_wr;
  logic [7:0] data_213f;
  logic [7:0] data_2100;

  // b-bus decode
  assign hit_213f = bus.pa == PA_213F;
  // full limit turns $2100 handling off
  assign limit_on = cfg.bright_limit != BRIGHT_FULL;
  assign hit_2100 = (bus.pa == PA_2100) & limit_on;

  // brightness nibble of the delayed write data
  assign over_limit = bus.data_dly[3:0] > cfg.bright_limit;

  assign cap_213f = ~evt.cycle_end & evt.pard_start & hit_213f;
  assign cap_2100 = ~evt.cycle_end & evt.pawr_start & hit_2100 & over_limit;

  // ppu byte with the region flag swapped in
  always_comb begin
    region_byte             = bus.data;
    region_byte[REGION_BIT] = cfg.region;
  end

  //////////////////////////////////////////////////////////////////////
  // $213f region substitution
  //////////////////////////////////////////////////////////////////////

  // force_rd high: ppu owns the bus until its byte is captured
  always_ff @(posedge CLK2) begin
    if (reset | evt.reset_strobe) begin
      force_rd <= 1'b0;
    end else if (evt.cycle_end) begin
      force_rd <= 1'b1;
    end else if (cap_213f) begin
      force_rd <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // $2100 brightness limit
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset | evt.reset_strobe) begin
      force_wr <= 1'b0;
    end else if (evt.cycle_end) begin
      force_wr <= 1'b0;
    end else if (cap_2100) begin
      force_wr <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (cap_213f) begin
      data_213f <= region_byte;
    end
    if (cap_2100) begin
      // keep the blank flag, clamp the brightness
      data_2100 <= {bus.data_dly[7:4], cfg.bright_limit};
    end
  end

  always_comb begin
    drive.en_213f   = hit_213f;
    drive.force_rd  = force_rd;
    drive.data_213f = data_213f;
    drive.en_2100   = hit_2100;
    drive.force_wr  = force_wr;
    drive.data_2100 = data_2100;
  end

endmodule

// ==== src/bus_drive_mux.sv ====
module bus_drive_mux
  import snes_pkg::*;
(
  input  snes_bus_t   bus,
  input  mcu_port_t   mcu,
  input  ppu_drive_t  drive,
  input  cart_cfg_t   cfg,
  input  logic [15:0] rom_rdata,
  output logic        rom_hit,
  output logic [7:0]  rom_byte,
  output psram_addr_t rom_addr,
  output logic        rom_we,
  output logic        rom_bhe,
  output logic        rom_ble,
  output logic [15:0] rom_wdata,
  output logic [7:0]  snes_data_out,
  output logic        snes_databus_dir,
  output logic        snes_databus_oe
);

  logic       mcu_hit;
  snes_addr_t rom_byte_addr;
  logic       lane_lo;
  logic       pard_213f;
  logic       pawr_2100;
  logic       drive_213f;
  logic       drive_2100;

  //////////////////////////////////////////////////////////////////////
  // psram side
  //////////////////////////////////////////////////////////////////////

  assign rom_hit = ~bus.romsel_n;
  assign mcu_hit = mcu.access_rd | mcu.access_wr;

  // mcu wins during its slot, console address stays inside the rom image
  assign rom_byte_addr = mcu_hit ? mcu.addr : (bus.addr & cfg.rom_mask);
  assign rom_addr      = rom_byte_addr[23:1];

  // odd byte address lives in the low lane
  assign lane_lo  = rom_byte_addr[0];
  assign rom_byte = lane_lo ? rom_rdata[7:0] : rom_rdata[15:8];

  // byte enables active low
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  // console never writes, only the mcu does
  assign rom_we    = ~mcu.access_wr;
  assign rom_wdata = {mcu.wdata, mcu.wdata};

  //////////////////////////////////////////////////////////////////////
  // console side
  //////////////////////////////////////////////////////////////////////

  assign pard_213f  = drive.en_213f & ~bus.pard_n;
  assign pawr_2100  = drive.en_2100 & ~bus.pawr_n;
  assign drive_213f = pard_213f & ~drive.force_rd;
  assign drive_2100 = pawr_2100 & drive.force_wr;

  // patched registers first, then rom data
  always_comb begin
    if (drive_213f) begin
      snes_data_out = drive.data_213f;
    end else if (drive_2100) begin
      snes_data_out = drive.data_2100;
    end else begin
      snes_data_out = rom_byte;
    end
  end

  // 1 = fpga drives the console, ppu keeps the bus while force_rd
  always_comb begin
    if (~bus.read_n | pard_213f) begin
      snes_databus_dir = ~(pard_213f & drive.force_rd);
    end else if (pawr_2100) begin
      snes_databus_dir = drive.force_wr;
    end else begin
      snes_databus_dir = 1'b0;
    end
  end

  // shifter enable, active low
  always_comb begin
    if (pard_213f | pawr_2100) begin
      snes_databus_oe = 1'b0;
    end else begin
      snes_databus_oe = ~rom_hit | (bus.read_n & bus.write_n);
    end
  end

endmodule

// ==== src/snes_main.sv ====
module snes_main
  import snes_pkg::*;
(
  input  logic        CLK2,
  input  logic        reset,
  input  snes_addr_t  snes_addr_in,
  input  snes_pa_t    snes_pa_in,
  input  logic        snes_read_in,
  input  logic        snes_write_in,
  input  logic        snes_romsel_in,
  input  logic        snes_pard_in,
  input  logic        snes_pawr_in,
  input  logic        snes_cpu_clk_in,
  input  logic [7:0]  snes_data_in,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  snes_addr_t  mcu_addr,
  input  logic [7:0]  mcu_wdata,
  input  cart_cfg_t   cfg,
  input  logic [15:0] rom_rdata,
  output logic [7:0]  snes_data_out,
  output logic        snes_databus_dir,
  output logic        snes_databus_oe,
  output logic        mcu_rdy,
  output logic [7:0]  mcu_rdata,
  output psram_addr_t rom_addr,
  output logic [15:0] rom_wdata,
  output logic        rom_we,
  output logic        rom_bhe,
  output logic        rom_ble
);

  // port names line up across the blocks
  snes_bus_t  bus;
  snes_evt_t  evt;
  logic       dead;
  logic       rom_hit;
  logic [7:0] rom_byte;
  mcu_port_t  mcu;
  ppu_drive_t drive;

  snes_bus_sync bus_sync_i (.*);

  mcu_psram_arbiter arbiter_i (.*);

  ppu_reg_patch reg_patch_i (.*);

  bus_drive_mux drive_mux_i (.*);

endmodule

// ==== verif/tb_snes_main.sv ====
module tb_snes_main
  import snes_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // mcu latency bound and half period of the console cpu clock
  localparam int RDY_BOUND = ROM_CYCLE_LEN + 8;
  localparam int CPU_HALF = 12;
  // rough per-test lengths summed, then some slack
  localparam int TEST_CYCLES = 2 + 2 * (RDY_BOUND + 3) + 2 * CPU_HALF
                             + 2 * (16 + CPU_HALF) + (4 * CPU_HALF + 4)
                             + (ADDR_DELAY + 10 + CPU_HALF)
                             + 2 * (ADDR_DELAY + 12 + CPU_HALF);
  localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

  logic        CLK2;
  logic        reset;
  snes_addr_t  snes_addr_in;
  snes_pa_t    snes_pa_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_pard_in;
  logic        snes_pawr_in;
  logic        snes_cpu_clk_in;
  logic [7:0]  snes_data_in;
  logic        mcu_rrq;
  logic        mcu_wrq;
  snes_addr_t  mcu_addr;
  logic [7:0]  mcu_wdata;
  cart_cfg_t   cfg;
  logic [15:0] rom_rdata;
  logic [7:0]  snes_data_out;
  logic        snes_databus_dir;
  logic        snes_databus_oe;
  logic        mcu_rdy;
  logic [7:0]  mcu_rdata;
  psram_addr_t rom_addr;
  logic [15:0] rom_wdata;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;

  integer seed = 56001;
  int     val_errs = 0;
  int     other_errs = 0;
  int     cycle_cnt = 0;
  int     mem_gen = 0;

  // sparse psram image, word addressed
  logic [15:0] psram [psram_addr_t];

  snes_main snes_main_i (.*);

  always #4 CLK2 = ~CLK2;

  //////////////////////////////////////////////////////////////////////
  // psram model
  //////////////////////////////////////////////////////////////////////

  // untouched words, pattern over the whole address
  function automatic logic [15:0] fill_word(input psram_addr_t a);
    return a[15:0] ^ {a[22:16], a[22:14]};
  endfunction

  function automatic logic [15:0] psram_word(input psram_addr_t a);
    if ($isunknown(a)) begin
      return 'x;
    end
    return psram.exists(a) ? psram[a] : fill_word(a);
  endfunction

  // console view: odd byte address is the low lane
  function automatic logic [7:0] model_byte(input snes_addr_t a);
    logic [15:0] w;
    w = psram_word(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic psram_store(input psram_addr_t a, input logic [15:0] wd,
                             input logic bhe_n, input logic ble_n);
    logic [15:0] w;
    w = psram_word(a);
    if (!bhe_n) begin
      w[15:8] = wd[15:8];
    end
    if (!ble_n) begin
      w[7:0] = wd[7:0];
    end
    psram[a] = w;
    mem_gen++;
  endtask

  task automatic preload(input snes_addr_t a);
    psram[a[23:1]] = $random(seed);
    mem_gen++;
  endtask

  // writes sampled mid cycle
  always @(negedge CLK2) begin
    if (rom_we === 1'b0) begin
      psram_store(rom_addr, rom_wdata, rom_bhe, rom_ble);
    end
  end

  // async read, refreshed on address change or store
  always @(rom_addr or mem_gen) begin
    rom_rdata = psram_word(rom_addr);
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_addr(input string name, input psram_addr_t got,
                            input psram_addr_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      val_errs++;
    end
  endtask

  // returns one time unit after the n-th rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK2);
    #1;
  endtask

  task automatic cpu_phase(input logic lvl, input int n);
    snes_cpu_clk_in = lvl;
    wait_cycles(n);
  endtask

  // one request pulse, then wait for mcu_rdy with a bound
  task automatic mcu_access(input logic wr, input snes_addr_t a,
                            input logic [7:0] d, input int bound);
    int n;
    wait_cycles(1);
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_rrq   = ~wr;
    mcu_wrq   = wr;
    wait_cycles(1);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    n = 0;
    while (mcu_rdy !== 1'b1 && n < bound) begin
      @(negedge CLK2);
      n++;
    end
    if (mcu_rdy !== 1'b1) begin
      $display("mcu_rdy did not come back within %0d cycles of a request", bound);
      other_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_we", rom_we, 1'b1);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b0);
    check_bit("snes_databus_oe", snes_databus_oe, 1'b1);
  endtask

  // console still dead, mcu gets the psram at once
  task automatic test_dead_mcu();
    snes_addr_t a;
    logic [7:0] d;
    a = $random(seed);
    d = $random(seed);
    mcu_access(1'b1, a, d, RDY_BOUND);
    check_byte("psram byte", model_byte(a), d);
    mcu_access(1'b0, a, 8'h00, RDY_BOUND);
    check_byte("mcu_rdata", mcu_rdata, d);
  endtask

  // both lanes, even then odd address
  task automatic test_rom_read();
    snes_addr_t a;
    snes_addr_t m;
    for (int lane = 0; lane < 2; lane++) begin
      a    = $random(seed);
      a[0] = lane[0];
      m    = a & cfg.rom_mask;
      preload(m);
      wait_cycles(1);
      snes_cpu_clk_in = 1'b1;
      snes_addr_in    = a;
      snes_romsel_in  = 1'b0;
      wait_cycles(2);
      snes_read_in = 1'b0;
      wait_cycles(10);
      @(negedge CLK2);
      check_addr("rom_addr", rom_addr, m[23:1]);
      check_byte("snes_data_out", snes_data_out, model_byte(m));
      check_bit("snes_databus_dir", snes_databus_dir, 1'b1);
      check_bit("snes_databus_oe", snes_databus_oe, 1'b0);
      // odd address enables only the low lane
      check_bit("rom_ble", rom_ble, (lane == 1) ? 1'b0 : 1'b1);
      check_bit("rom_bhe", rom_bhe, (lane == 1) ? 1'b1 : 1'b0);
      wait_cycles(1);
      snes_read_in   = 1'b1;
      snes_romsel_in = 1'b1;
      cpu_phase(1'b0, CPU_HALF);
    end
  endtask

  // console keeps reading rom, mcu waits for the cycle end slot
  task automatic test_mcu_busy();
    snes_addr_t a;
    a = $random(seed);
    preload(a);
    wait_cycles(1);
    snes_addr_in   = $random(seed);
    snes_romsel_in = 1'b0;
    snes_read_in   = 1'b0;
    fork
      begin
        repeat (2) begin
          cpu_phase(1'b1, CPU_HALF);
          cpu_phase(1'b0, CPU_HALF);
        end
      end
      mcu_access(1'b0, a, 8'h00, 2 * CPU_HALF + RDY_BOUND);
    join
    check_byte("mcu_rdata", mcu_rdata, model_byte(a));
    wait_cycles(1);
    snes_romsel_in = 1'b1;
    snes_read_in   = 1'b1;
  endtask

  task automatic test_213f();
    logic [7:0] v;
    logic [7:0] exp;
    v               = $random(seed);
    exp             = v;
    exp[REGION_BIT] = cfg.region;
    wait_cycles(1);
    snes_cpu_clk_in = 1'b1;
    snes_pa_in      = PA_213F;
    // ppu drives its byte first
    snes_data_in    = v;
    wait_cycles(ADDR_DELAY + 1);
    snes_pard_in = 1'b0;
    wait_cycles(6);
    // ppu released, pins now show something else
    snes_data_in = ~v;
    @(negedge CLK2);
    check_byte("snes_data_out", snes_data_out, exp);
    check_bit("snes_databus_dir", snes_databus_dir, 1'b1);
    wait_cycles(1);
    snes_pard_in = 1'b1;
    snes_pa_in   = 8'hFF;
    cpu_phase(1'b0, CPU_HALF);
  endtask

  // pass 0 limited, pass 1 with the limit off
  task automatic test_2100();
    logic [3:0] lim;
    logic [7:0] w;
    lim    = {$random(seed)} % 14;
    w      = $random(seed);
    w[3:0] = lim + 1 + {$random(seed)} % (14 - lim);
    for (int pass = 0; pass < 2; pass++) begin
      wait_cycles(1);
      cfg.bright_limit = (pass == 0) ? lim : BRIGHT_FULL;
      snes_cpu_clk_in  = 1'b1;
      snes_pa_in       = PA_2100;
      snes_data_in     = w;
      wait_cycles(ADDR_DELAY + 1);
      snes_pawr_in = 1'b0;
      wait_cycles(8);
      @(negedge CLK2);
      if (pass == 0) begin
        check_bit("snes_databus_dir", snes_databus_dir, 1'b1);
        check_byte("snes_data_out", snes_data_out, {w[7:4], lim});
      end else begin
        check_bit("snes_databus_dir", snes_databus_dir, 1'b0);
      end
      wait_cycles(1);
      snes_pawr_in = 1'b1;
      snes_pa_in   = 8'hFF;
      cpu_phase(1'b0, CPU_HALF);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    CLK2            = 1'b0;
    reset           = 1'b1;
    snes_addr_in    = '0;
    snes_pa_in      = 8'hFF;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_pard_in    = 1'b1;
    snes_pawr_in    = 1'b1;
    snes_cpu_clk_in = 1'b0;
    snes_data_in    = '0;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = '0;
    mcu_wdata       = '0;
    rom_rdata       = '0;
    cfg.region       = $random(seed);
    cfg.bright_limit = BRIGHT_FULL;
    cfg.rom_mask     = 24'h3FFFFF;
    wait_cycles(2);
    reset = 1'b0;
    test_reset_state();
    test_dead_mcu();
    // first console cycle wakes the core up
    wait_cycles(1);
    cpu_phase(1'b1, CPU_HALF);
    cpu_phase(1'b0, CPU_HALF);
    test_rom_read();
    test_mcu_busy();
    test_213f();
    test_2100();
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== src.f ====
src/snes_pkg.sv
src/snes_bus_sync.sv
src/mcu_psram_arbiter.sv
src/ppu_reg_patch.sv
src/bus_drive_mux.sv
src/snes_main.sv
verif/tb_snes_main.sv

// ==== Bender.yml ====
package:
  name: snes_main

sources:
  - src/snes_pkg.sv
  - src/snes_bus_sync.sv
  - src/mcu_psram_arbiter.sv
  - src/ppu_reg_patch.sv
  - src/bus_drive_mux.sv
  - src/snes_main.sv
  - target: test
    files:
      - verif/tb_snes_main.sv
